// File: hdl/bldc_pkg.sv
// ==========================================================================
// BLDC gate driver shared types
// ==========================================================================

package bldc_pkg;

    // width of the duty word and of the pwm carrier count
    localparam int DUTY_W = 10;

    // what one phase of the bridge is doing in the current sector
    typedef enum logic [1:0] {
        MODE_FLOAT = 2'd0,  // both fets off, phase left high impedance
        MODE_LOW   = 2'd1,  // low side held on, phase tied to ground
        MODE_PWM   = 2'd2   // switched against the carrier with dead time
    } phase_mode_e;

    // drive command as it arrives on the valid/ready port
    typedef struct packed {
        logic              enable;   // clear -> all phases float
        logic              reverse;  // mirrored commutation table
        logic [DUTY_W-1:0] duty;     // compared against the carrier count
    } drive_cmd_t;

    // gate pair of one half bridge
    typedef struct packed {
        logic hi;  // high side fet, phase to supply
        logic lo;  // low side fet, phase to ground
    } gate_t;

endpackage

// File: hdl/pwm_carrier.sv
// ==========================================================================
// PWM carrier counter
// ==========================================================================

`timescale 1ns/10ps

module pwm_carrier #(
    parameter int unsigned MAX_COUNT = 1023  // last count, period is MAX_COUNT+1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [bldc_pkg::DUTY_W-1:0] count,
    output logic                        period_start
);

    import bldc_pkg::*;

    // terminal count trimmed to the counter width
    localparam logic [DUTY_W-1:0] LAST = MAX_COUNT[DUTY_W-1:0];

    // one time base for all three phases so their edges line up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count == LAST) begin
            count <= '0;              // wrap, next cycle opens a new period
        end else begin
            count <= count + 1'b1;
        end
    end

    // first count of every period
    // the sequencer swaps in a new duty here so no pulse gets clipped
    assign period_start = (count == '0);

endmodule

// File: hdl/phase_driver.sv
// ==========================================================================
// Half bridge driver with dead time
// ==========================================================================

`timescale 1ns/10ps

module phase_driver #(
    parameter int unsigned MAX_COUNT = 1023,  // last carrier count
    parameter int unsigned DEAD_TIME = 8      // clocks with both fets off
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [bldc_pkg::DUTY_W-1:0] count,
    input  bldc_pkg::phase_mode_e       mode,
    input  logic [bldc_pkg::DUTY_W-1:0] duty,
    output bldc_pkg::gate_t             gate
);

    import bldc_pkg::*;

    // one extra bit so count + dead time cannot wrap in the compare
    localparam logic [DUTY_W:0] MAX_EXT  = MAX_COUNT[DUTY_W:0];
    localparam logic [DUTY_W:0] DEAD_EXT = DEAD_TIME[DUTY_W:0];

    logic [DUTY_W:0] count_ext;
    logic [DUTY_W:0] lead_ext;    // count looking ahead by the dead time
    logic [DUTY_W:0] duty_ext;
    logic            hi_cmp;
    logic            lo_cmp;
    gate_t           gate_next;

    assign count_ext = {1'b0, count};
    assign duty_ext  = {1'b0, duty};
    assign lead_ext  = count_ext + DEAD_EXT;

    // high side drops DEAD_TIME counts before the duty point,
    // so the falling edge of hi leaves a gap before lo turns on
    assign hi_cmp = (lead_ext < duty_ext);

    // low side starts at the duty point and stops DEAD_TIME counts
    // before the wrap, leaving the gap ahead of the next hi pulse
    assign lo_cmp = (count_ext >= duty_ext) && (lead_ext <= MAX_EXT);

    always_comb begin
        gate_next = '0;                          // float unless told otherwise
        case (mode)
            MODE_PWM: begin
                gate_next.hi = hi_cmp;
                // zero duty never switches, just clamp the phase to ground
                gate_next.lo = (duty == '0) ? 1'b1 : lo_cmp;
            end
            MODE_LOW: begin
                gate_next.lo = 1'b1;             // static, no dead time needed
            end
            default: begin
                gate_next = '0;                  // MODE_FLOAT and unused code
            end
        endcase
    end

    // registered outputs, the compare tree settles before it reaches a fet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate <= '0;
        end else begin
            gate <= gate_next;
        end
    end

endmodule

// File: hdl/commutation_sequencer.sv
// ==========================================================================
// Six-step commutation and command holding
// ==========================================================================

`timescale 1ns/10ps

module commutation_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [2:0]                  hall,
    input  bldc_pkg::drive_cmd_t        cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic                        period_start,
    output bldc_pkg::phase_mode_e       mode_u,
    output bldc_pkg::phase_mode_e       mode_v,
    output bldc_pkg::phase_mode_e       mode_w,
    output logic [bldc_pkg::DUTY_W-1:0] duty
);

    import bldc_pkg::*;

    logic [2:0] hall_meta;      // first synchroniser stage
    logic [2:0] hall_sync;      // safe to decode
    logic       pending_valid;  // holding register occupied
    drive_cmd_t pending_cmd;
    drive_cmd_t applied_cmd;    // what the bridge runs on right now
    logic       accept;
    logic [2:0] fwd_pwm;        // one-hot per phase, bit 0 = U
    logic [2:0] fwd_low;
    logic [2:0] pwm_sel;
    logic [2:0] low_sel;

    // pick the phase mode from the two one-hot selects
    function automatic phase_mode_e pick_mode(input logic pwm, input logic low);
        if (pwm) begin
            return MODE_PWM;
        end
        return low ? MODE_LOW : MODE_FLOAT;
    endfunction

    // hall sensors are asynchronous to clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hall_meta <= '0;
            hall_sync <= '0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
        end
    end

    // one-entry command buffer
    // ready only while empty, a second command stalls until the next period
    assign cmd_ready = !pending_valid;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_valid <= 1'b0;
        end else if (accept) begin
            pending_valid <= 1'b1;   // taken on a period start still waits a period
        end else if (period_start) begin
            pending_valid <= 1'b0;   // moved to applied below
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending_cmd <= cmd;
        end
    end

    // duty and direction only change at the top of a carrier period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            applied_cmd <= '0;       // disabled, duty 0
        end else if (period_start && pending_valid) begin
            applied_cmd <= pending_cmd;
        end
    end

    assign duty = applied_cmd.duty;

    // forward 120 degree hall table, (pwm phase, low phase)
    always_comb begin
        fwd_pwm = 3'b000;
        fwd_low = 3'b000;
        case (hall_sync)
            3'b101: begin fwd_pwm = 3'b001; fwd_low = 3'b010; end  // U, V
            3'b100: begin fwd_pwm = 3'b001; fwd_low = 3'b100; end  // U, W
            3'b110: begin fwd_pwm = 3'b010; fwd_low = 3'b100; end  // V, W
            3'b010: begin fwd_pwm = 3'b010; fwd_low = 3'b001; end  // V, U
            3'b011: begin fwd_pwm = 3'b100; fwd_low = 3'b001; end  // W, U
            3'b001: begin fwd_pwm = 3'b100; fwd_low = 3'b010; end  // W, V
            default: begin
                fwd_pwm = 3'b000;    // 000 and 111 are sensor faults, float all
                fwd_low = 3'b000;
            end
        endcase
    end

    // reverse rotation swaps the driven and the grounded phase
    assign pwm_sel = !applied_cmd.enable ? 3'b000 :
                     applied_cmd.reverse ? fwd_low : fwd_pwm;
    assign low_sel = !applied_cmd.enable ? 3'b000 :
                     applied_cmd.reverse ? fwd_pwm : fwd_low;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_u <= MODE_FLOAT;
            mode_v <= MODE_FLOAT;
            mode_w <= MODE_FLOAT;
        end else begin
            mode_u <= pick_mode(pwm_sel[0], low_sel[0]);
            mode_v <= pick_mode(pwm_sel[1], low_sel[1]);
            mode_w <= pick_mode(pwm_sel[2], low_sel[2]);
        end
    end

endmodule

// File: hdl/bldc_drive_top.sv
// ==========================================================================
// Three-phase BLDC gate driver top
// ==========================================================================

`timescale 1ns/10ps

module bldc_drive_top #(
    parameter int unsigned MAX_COUNT = 1023,  // carrier period is MAX_COUNT+1
    parameter int unsigned DEAD_TIME = 8      // dead time in clocks
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [2:0]                 hall,
    input  bldc_pkg::drive_cmd_t       cmd,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    output bldc_pkg::gate_t [2:0]      gates       // [0] U, [1] V, [2] W
);

    import bldc_pkg::*;

    logic [DUTY_W-1:0] count;         // shared carrier
    logic              period_start;
    logic [DUTY_W-1:0] duty;          // applied duty, same for all phases
    phase_mode_e       mode_u;
    phase_mode_e       mode_v;
    phase_mode_e       mode_w;

    pwm_carrier #(
        .MAX_COUNT    (MAX_COUNT)
    ) pwm_carrier_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .count        (count),
        .period_start (period_start)
    );

    commutation_sequencer commutation_sequencer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .hall         (hall),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .period_start (period_start),
        .mode_u       (mode_u),
        .mode_v       (mode_v),
        .mode_w       (mode_w),
        .duty         (duty)
    );

    // one half bridge per phase, all on the same carrier
    phase_driver #(
        .MAX_COUNT (MAX_COUNT),
        .DEAD_TIME (DEAD_TIME)
    ) phase_driver_u_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .mode  (mode_u),
        .duty  (duty),
        .gate  (gates[0])
    );

    phase_driver #(
        .MAX_COUNT (MAX_COUNT),
        .DEAD_TIME (DEAD_TIME)
    ) phase_driver_v_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .mode  (mode_v),
        .duty  (duty),
        .gate  (gates[1])
    );

    phase_driver #(
        .MAX_COUNT (MAX_COUNT),
        .DEAD_TIME (DEAD_TIME)
    ) phase_driver_w_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .mode  (mode_w),
        .duty  (duty),
        .gate  (gates[2])
    );

endmodule

// File: tb/bldc_drive_assert.sv
// ==========================================================================
// BLDC gate driver assertions
// ==========================================================================

`timescale 1ns/10ps

module bldc_drive_assert (
    input logic                  clk,
    input logic                  rst_n,
    input bldc_pkg::drive_cmd_t  cmd,
    input logic                  cmd_valid,
    input logic                  cmd_ready,
    input bldc_pkg::gate_t [2:0] gates
);

    // no shoot-through, hi and lo of one half bridge never overlap
    for (genvar p = 0; p < 3; p++) begin : g_phase
        assert property (@(posedge clk) !(gates[p].hi && gates[p].lo))
            else $error("phase %0d has both gates on", p);
    end

    // a stalled command keeps valid up and its contents frozen
    assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd)))
        else $error("command changed or dropped while stalled");

    // bridge fully off while in reset
    assert property (@(posedge clk) !rst_n |-> (gates == '0))
        else $error("gate active during reset");

endmodule

// attach to every instance of the top level
bind bldc_drive_top bldc_drive_assert bldc_drive_assert_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .gates     (gates)
);

// File: tb/tb_bldc_drive.sv
// ==========================================================================
// BLDC gate driver testbench
// ==========================================================================

`timescale 1ns/10ps

module tb_bldc_drive;

    import bldc_pkg::*;

    localparam int MAX_COUNT = 63;
    localparam int DEAD_TIME = 4;
    localparam int PERIOD    = MAX_COUNT + 1;
    // reset 2, forward 10, reverse 10, edge duties 10, back-pressure 6, margin 2
    localparam int TEST_PERIODS = 40;
    localparam int CYCLE_LIMIT  = TEST_PERIODS * PERIOD;

    // forward table, hall code -> switched phase and grounded phase
    localparam logic [2:0] STEP_CODE [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};
    localparam int         STEP_PWM  [6] = '{0, 0, 1, 1, 2, 2};
    localparam int         STEP_LOW  [6] = '{1, 2, 2, 0, 0, 1};

    logic        clk;
    logic        rst_n;
    logic [2:0]  hall;
    drive_cmd_t  cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    gate_t [2:0] gates;         // [0] U, [1] V, [2] W

    int          cycle_count;
    int          errors;
    int          checks;
    int          tests;
    logic [15:0] lfsr_state;
    int          hi_cnt [3];    // on-cycles over one carrier period
    int          lo_cnt [3];

    bldc_drive_top #(
        .MAX_COUNT (MAX_COUNT),
        .DEAD_TIME (DEAD_TIME)
    ) bldc_drive_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .hall      (hall),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .gates     (gates)
    );

    always #2 clk = ~clk;       // 4 ns period

    // hard stop so a stuck handshake cannot hang the run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            value = value * 2 + (lfsr_state[0] ? 1 : 0);
        end
    endtask

    // reference model: high side runs while count + dead time < duty
    function automatic int exp_hi(input int duty);
        int n;
        n = duty - DEAD_TIME;
        n = (n < 0) ? 0 : n;
        return (n > PERIOD) ? PERIOD : n;
    endfunction

    // low side from the duty point up to MAX_COUNT - dead time, duty 0 clamps
    function automatic int exp_lo(input int duty);
        int n;
        if (duty == 0) begin
            return PERIOD;
        end
        n = MAX_COUNT - DEAD_TIME - duty + 1;
        return (n < 0) ? 0 : n;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
    endtask

    // ready rises on the edge where the held command goes live
    task automatic wait_applied();
        wait_ready();
        repeat (3) @(posedge clk);                  // mode register, then gate register
    endtask

    task automatic send_cmd(input logic en, input logic rev, input int duty);
        @(posedge clk);
        cmd       <= {en, rev, duty[DUTY_W-1:0]};
        cmd_valid <= 1'b1;
        wait_ready();
        @(posedge clk);                             // transfer edge
        cmd_valid <= 1'b0;
    endtask

    task automatic set_hall(input logic [2:0] code);
        @(posedge clk);
        hall <= code;
        repeat (5) @(posedge clk);                  // 4 cycle hall to gate latency
    endtask

    task automatic measure_period();
        for (int p = 0; p < 3; p++) begin
            hi_cnt[p] = 0;
            lo_cnt[p] = 0;
        end
        repeat (PERIOD) begin
            @(negedge clk);                         // gates stable mid cycle
            for (int p = 0; p < 3; p++) begin
                if (gates[p].hi) hi_cnt[p]++;
                if (gates[p].lo) lo_cnt[p]++;
            end
        end
    endtask

    // pwm_p / low_p of -1 means no phase has that role
    task automatic check_counts(input int pwm_p, input int low_p, input int duty);
        int exp_h;
        int exp_l;
        for (int p = 0; p < 3; p++) begin
            exp_h = 0;
            exp_l = 0;
            if (p == pwm_p) begin
                exp_h = exp_hi(duty);
                exp_l = exp_lo(duty);
            end else if (p == low_p) begin
                exp_l = PERIOD;                     // grounded all period
            end
            check_value($sformatf("gates[%0d].hi on-count", p), hi_cnt[p], exp_h);
            check_value($sformatf("gates[%0d].lo on-count", p), lo_cnt[p], exp_l);
        end
    endtask

    task automatic reset_state();
        int start;
        start = errors;
        @(negedge clk);
        check_value("gates", {26'd0, gates}, 0);
        check_value("cmd_ready", {31'd0, cmd_ready}, 1);
        // applied command is still disabled, every code must float
        for (int h = 0; h < 8; h++) begin
            set_hall(h[2:0]);
            @(negedge clk);
            check_value("gates", {26'd0, gates}, 0);
        end
        report_test("reset state", start);
    endtask

    task automatic six_step_rotation(input logic rev);
        int start;
        int duty;
        start = errors;
        take_bits(7, duty);                         // up to 127, past the cap
        send_cmd(1'b1, rev, duty);
        wait_applied();
        for (int k = 0; k < 6; k++) begin
            set_hall(STEP_CODE[k]);
            measure_period();
            if (rev) begin
                check_counts(STEP_LOW[k], STEP_PWM[k], duty);   // roles swapped
            end else begin
                check_counts(STEP_PWM[k], STEP_LOW[k], duty);
            end
        end
        if (rev) begin
            report_test("reverse six-step", start);
        end else begin
            report_test("forward six-step", start);
        end
    endtask

    task automatic edge_duties();
        int start;
        start = errors;
        send_cmd(1'b1, 1'b0, PERIOD);               // full duty
        wait_applied();
        set_hall(3'b101);
        measure_period();
        check_counts(0, 1, PERIOD);
        send_cmd(1'b1, 1'b0, 0);
        wait_applied();
        measure_period();
        check_counts(0, 1, 0);
        set_hall(3'b000);                           // sensor fault codes
        measure_period();
        check_counts(-1, -1, 0);
        set_hall(3'b111);
        measure_period();
        check_counts(-1, -1, 0);
        report_test("edge duties", start);
    endtask

    task automatic back_pressure();
        int start;
        int duty_a;
        int duty_b;
        start = errors;
        take_bits(6, duty_a);
        take_bits(6, duty_b);
        set_hall(3'b101);                           // U switched, V grounded
        @(posedge clk);
        cmd       <= {1'b1, 1'b0, duty_a[DUTY_W-1:0]};
        cmd_valid <= 1'b1;
        wait_ready();
        @(posedge clk);                             // first command taken
        cmd.duty <= duty_b[DUTY_W-1:0];             // second one right behind
        @(negedge clk);
        check_value("cmd_ready", {31'd0, cmd_ready}, 0);
        wait_ready();                               // stalls until first goes live
        @(posedge clk);
        cmd_valid <= 1'b0;
        // first window is exactly one period of duty_a, then duty_b takes over
        measure_period();
        check_counts(0, 1, duty_a);
        measure_period();
        check_counts(0, 1, duty_b);
        report_test("back-pressure", start);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        hall        = 3'b000;
        cmd         = '0;
        cmd_valid   = 1'b0;
        cycle_count = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        lfsr_state  = 16'd16666;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        six_step_rotation(1'b0);
        six_step_rotation(1'b1);
        edge_duties();
        back_pressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: bldc_drive.f
hdl/bldc_pkg.sv
hdl/pwm_carrier.sv
hdl/phase_driver.sv
hdl/commutation_sequencer.sv
hdl/bldc_drive_top.sv
tb/bldc_drive_assert.sv
tb/tb_bldc_drive.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the BLDC gate driver testbench with Verilator
# the result is taken from the pass line in sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --assert --timing \
    --top-module tb_bldc_drive \
    -f bldc_drive.f \
    -o tb_bldc_drive > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_bldc_drive > sim.log 2>&1 || echo "simulator returned an error status"

grep -qxF "** PASS **" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
